//--- cicInterpolate.sv
`timescale 1ns/1ps
`default_nettype none

module cicInterpolate import interpPkg::*; (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         sampleEn,
    input  wire sample_t                cicIn,
    interpCfgIf.datapath                cfg,
    output logic signed [cicWidth-1:0]  cicOut
);

    typedef logic signed [cicWidth-1:0] cic_t;

    cic_t       combIn;
    cic_t       combDly [cicStages];
    cic_t       combOut [cicStages];
    cic_t       integ [cicStages];
    cic_t       stuffed;
    logic [1:0] bypassDly;
    logic       cicClear;

    // Leaving bypass restarts the filter two samples later
    always_ff @(posedge clk) begin
        if (reset) begin
            bypassDly <= '0;
            cicClear <= 1'b0;
        end else begin
            if (sampleEn) begin
                bypassDly <= {bypassDly[0], cfg.bypass};
            end
            cicClear <= sampleEn && bypassDly[1] && !bypassDly[0];
        end
    end

    // Comb section at the input rate
    always_ff @(posedge clk) begin
        if (reset || cicClear) begin
            combIn <= '0;
            for (int k = 0; k < cicStages; k++) begin
                combDly[k] <= '0;
                combOut[k] <= '0;
            end
        end else if (sampleEn) begin
            combIn <= cic_t'(cicIn);
            combDly[0] <= combIn;
            combOut[0] <= combIn - combDly[0];
            for (int k = 1; k < cicStages; k++) begin
                combDly[k] <= combOut[k-1];
                combOut[k] <= combOut[k-1] - combDly[k];
            end
        end
    end

    // Zero stuffing up to the clock rate
    assign stuffed = sampleEn ? combOut[cicStages-1] : '0;

    // Integrators wrap freely, final width covers the gain
    always_ff @(posedge clk) begin
        if (reset || cicClear) begin
            for (int k = 0; k < cicStages; k++) begin
                integ[k] <= '0;
            end
        end else begin
            integ[0] <= integ[0] + stuffed;
            for (int k = 1; k < cicStages; k++) begin
                integ[k] <= integ[k] + integ[k-1];
            end
        end
    end

    assign cicOut = integ[cicStages-1];

    strobeSpacing: assert property (@(posedge clk) disable iff (reset) sampleEn |=> !sampleEn);

endmodule

`default_nettype wire

//--- compFir.sv
`timescale 1ns/1ps
`default_nettype none

module compFir import interpPkg::*; (
    input  wire             clk,
    input  wire             reset,
    input  wire             sampleEn,
    input  wire sample_t    dataIn,
    interpCfgIf.datapath    cfg,
    output sample_t         firOut
);

    sample_t taps [firTaps];
    wide_t   acc;
    logic    loadOut;

    // Delay line, tap 0 is the newest sample
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < firTaps; k++) begin
                taps[k] <= '0;
            end
            loadOut <= 1'b0;
        end else begin
            loadOut <= sampleEn;
            if (sampleEn) begin
                taps[0] <= dataIn;
                for (int k = 1; k < firTaps; k++) begin
                    taps[k] <= taps[k-1];
                end
            end
        end
    end

    // Sum of products, coefficients carry fracBits of fraction
    always_comb begin
        acc = '0;
        for (int k = 0; k < firTaps; k++) begin
            acc = acc + wide_t'(taps[k]) * wide_t'(cfg.coef[k]);
        end
    end

    // Output lands one cycle after the delay line moves
    always_ff @(posedge clk) begin
        if (reset) begin
            firOut <= '0;
        end else if (loadOut) begin
            firOut <= saturate(acc >>> fracBits);
        end
    end

endmodule

`default_nettype wire

//--- gainScale.sv
`timescale 1ns/1ps
`default_nettype none

module gainScale import interpPkg::*; (
    input  wire                             clk,
    input  wire                             reset,
    input  wire logic signed [cicWidth-1:0] cicOut,
    interpCfgIf.datapath                    cfg,
    output sample_t                         scaled
);

    sample_t shifted;
    wide_t   product;

    // Mantissa is signed with fracBits of fraction
    assign product = wide_t'(shifted) * wide_t'(cfg.mantissa);

    always_ff @(posedge clk) begin
        if (reset) begin
            shifted <= '0;
            scaled <= '0;
        end else begin
            // Stage 1, exponent shift
            shifted <= saturate(wide_t'(cicOut) >>> cfg.exponent);
            // Stage 2, mantissa multiply
            scaled <= saturate(product >>> fracBits);
        end
    end

endmodule

`default_nettype wire

//--- interpCfgIf.sv
`timescale 1ns/1ps
`default_nettype none

interface interpCfgIf import interpPkg::*; ();

    logic                bypass;
    logic                test;
    logic                invert;
    logic                bypassEq;
    sample_t             testValue;
    logic [expWidth-1:0] exponent;
    sample_t             mantissa;
    sample_t             coef [firTaps];

    modport regs (
        output bypass, test, invert, bypassEq, testValue, exponent, mantissa, coef
    );

    modport datapath (
        input bypass, test, invert, bypassEq, testValue, exponent, mantissa, coef
    );

endinterface

`default_nettype wire

//--- interpPkg.sv
`default_nettype none

package interpPkg;

    localparam int sampleWidth = 18;
    localparam int fracBits = 16;
    localparam int firTaps = 4;
    localparam int interpRate = 4;
    localparam int cicStages = 3;
    localparam int cicWidth = 24;
    localparam int expWidth = 5;
    localparam int wideWidth = 48;
    localparam int addrWidth = 6;
    localparam int dataWidth = 32;
    localparam int regCount = 4 + firTaps;
    localparam int regIdxWidth = $clog2(regCount);

    // Register map, byte offsets
    localparam logic [addrWidth-1:0] regControl = 6'h00;
    localparam logic [addrWidth-1:0] regTestValue = 6'h04;
    localparam logic [addrWidth-1:0] regExponent = 6'h08;
    localparam logic [addrWidth-1:0] regMantissa = 6'h0C;
    localparam logic [addrWidth-1:0] regCoef0 = 6'h10;

    localparam logic [1:0] respOkay = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;

    typedef logic signed [sampleWidth-1:0] sample_t;
    typedef logic signed [wideWidth-1:0] wide_t;

    // Clamp to the sample range
    function automatic sample_t saturate(input wide_t value);
        sample_t result;
        if (&value[wideWidth-1:sampleWidth-1] || ~|value[wideWidth-1:sampleWidth-1]) begin
            result = value[sampleWidth-1:0];
        end else if (value[wideWidth-1]) begin
            result = {1'b1, {(sampleWidth-1){1'b0}}};
        end else begin
            result = {1'b0, {(sampleWidth-1){1'b1}}};
        end
        return result;
    endfunction

endpackage

`default_nettype wire

//--- interpRegs.sv
`timescale 1ns/1ps
`default_nettype none

module interpRegs import interpPkg::*; (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     awvalid,
    output logic                    awready,
    input  wire  [addrWidth-1:0]    awaddr,
    input  wire                     wvalid,
    output logic                    wready,
    input  wire  [dataWidth-1:0]    wdata,
    input  wire  [dataWidth/8-1:0]  wstrb,
    output logic                    bvalid,
    input  wire                     bready,
    output logic [1:0]              bresp,
    input  wire                     arvalid,
    output logic                    arready,
    input  wire  [addrWidth-1:0]    araddr,
    output logic                    rvalid,
    input  wire                     rready,
    output logic [dataWidth-1:0]    rdata,
    output logic [1:0]              rresp,
    interpCfgIf.regs                cfg
);

    logic [dataWidth-1:0]   words [regCount];
    logic [regIdxWidth:0]   wrSel;
    logic [regIdxWidth:0]   rdSel;
    logic [dataWidth-1:0]   wrWord;
    logic                   wrEn;
    logic                   rdEn;

    // MSB flags a mapped offset, low bits index the word view
    function automatic logic [regIdxWidth:0] regIndex(input logic [addrWidth-1:0] addr);
        logic [regIdxWidth:0] idx;
        idx = '0;
        case (addr)
            regControl:   idx = {1'b1, regIdxWidth'(0)};
            regTestValue: idx = {1'b1, regIdxWidth'(1)};
            regExponent:  idx = {1'b1, regIdxWidth'(2)};
            regMantissa:  idx = {1'b1, regIdxWidth'(3)};
            default: begin
                for (int k = 0; k < firTaps; k++) begin
                    if (addr == regCoef0 + addrWidth'(4 * k)) begin
                        idx = {1'b1, regIdxWidth'(4 + k)};
                    end
                end
            end
        endcase
        return idx;
    endfunction

    always_comb begin
        words[0] = {{(dataWidth-4){1'b0}}, cfg.bypassEq, cfg.invert, cfg.test, cfg.bypass};
        words[1] = {{(dataWidth-sampleWidth){1'b0}}, cfg.testValue};
        words[2] = {{(dataWidth-expWidth){1'b0}}, cfg.exponent};
        words[3] = {{(dataWidth-sampleWidth){1'b0}}, cfg.mantissa};
        for (int k = 0; k < firTaps; k++) begin
            words[4 + k] = {{(dataWidth-sampleWidth){1'b0}}, cfg.coef[k]};
        end
    end

    assign wrSel = regIndex(awaddr);
    assign rdSel = regIndex(araddr);

    // AW and W are taken together, one write outstanding
    assign wrEn = awvalid && wvalid && !bvalid;
    assign awready = wrEn;
    assign wready = wrEn;
    assign rdEn = arvalid && !rvalid;
    assign arready = rdEn;

    // Byte merge of the write data into the current word
    always_comb begin
        wrWord = words[wrSel[regIdxWidth-1:0]];
        for (int b = 0; b < dataWidth / 8; b++) begin
            if (wstrb[b]) begin
                wrWord[8*b +: 8] = wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg.bypass <= 1'b0;
            cfg.test <= 1'b0;
            cfg.invert <= 1'b0;
            cfg.bypassEq <= 1'b0;
            cfg.testValue <= '0;
            cfg.exponent <= '0;
            cfg.mantissa <= sample_t'(1 << fracBits);
            for (int k = 1; k < firTaps; k++) begin
                cfg.coef[k] <= '0;
            end
            cfg.coef[0] <= sample_t'(1 << fracBits);
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wrEn && wrSel[regIdxWidth]) begin
                case (wrSel[regIdxWidth-1:0])
                    3'd0: begin
                        cfg.bypass <= wrWord[0];
                        cfg.test <= wrWord[1];
                        cfg.invert <= wrWord[2];
                        cfg.bypassEq <= wrWord[3];
                    end
                    3'd1: cfg.testValue <= $signed(wrWord[sampleWidth-1:0]);
                    3'd2: cfg.exponent <= wrWord[expWidth-1:0];
                    3'd3: cfg.mantissa <= $signed(wrWord[sampleWidth-1:0]);
                    default: cfg.coef[wrSel[regIdxWidth-1:0] - 4] <= $signed(wrWord[sampleWidth-1:0]);
                endcase
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (wrEn) begin
                bvalid <= 1'b1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (rdEn) begin
                rvalid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            bresp <= wrSel[regIdxWidth] ? respOkay : respSlvErr;
        end
        if (rdEn) begin
            rdata <= rdSel[regIdxWidth] ? words[rdSel[regIdxWidth-1:0]] : '0;
            rresp <= rdSel[regIdxWidth] ? respOkay : respSlvErr;
        end
    end

    bHold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp));

    rHold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

//--- interpolate.f
interpPkg.sv
interpCfgIf.sv
interpRegs.sv
compFir.sv
cicInterpolate.sv
gainScale.sv
outputSelect.sv
interpolate.sv
tbInterpolate.sv

//--- interpolate.sv
`timescale 1ns/1ps
`default_nettype none

module interpolate import interpPkg::*; (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     awvalid,
    output logic                    awready,
    input  wire  [addrWidth-1:0]    awaddr,
    input  wire                     wvalid,
    output logic                    wready,
    input  wire  [dataWidth-1:0]    wdata,
    input  wire  [dataWidth/8-1:0]  wstrb,
    output logic                    bvalid,
    input  wire                     bready,
    output logic [1:0]              bresp,
    input  wire                     arvalid,
    output logic                    arready,
    input  wire  [addrWidth-1:0]    araddr,
    output logic                    rvalid,
    input  wire                     rready,
    output logic [dataWidth-1:0]    rdata,
    output logic [1:0]              rresp,
    input  wire sample_t            dataIn,
    input  wire                     sampleEn,
    output sample_t                 dataOut
);

    interpCfgIf cfg ();

    sample_t                    firOut;
    sample_t                    cicIn;
    logic signed [cicWidth-1:0] cicOut;
    sample_t                    scaled;

    interpRegs u_interpRegs (
        .clk     (clk),
        .reset   (reset),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .cfg     (cfg.regs)
    );

    compFir u_compFir (
        .clk      (clk),
        .reset    (reset),
        .sampleEn (sampleEn),
        .dataIn   (dataIn),
        .cfg      (cfg.datapath),
        .firOut   (firOut)
    );

    // Equalizer bypass skips the compensation FIR
    assign cicIn = cfg.bypassEq ? dataIn : firOut;

    cicInterpolate u_cicInterpolate (
        .clk      (clk),
        .reset    (reset),
        .sampleEn (sampleEn),
        .cicIn    (cicIn),
        .cfg      (cfg.datapath),
        .cicOut   (cicOut)
    );

    gainScale u_gainScale (
        .clk    (clk),
        .reset  (reset),
        .cicOut (cicOut),
        .cfg    (cfg.datapath),
        .scaled (scaled)
    );

    outputSelect u_outputSelect (
        .clk      (clk),
        .reset    (reset),
        .sampleEn (sampleEn),
        .dataIn   (dataIn),
        .scaled   (scaled),
        .cfg      (cfg.datapath),
        .dataOut  (dataOut)
    );

endmodule

`default_nettype wire

//--- outputSelect.sv
`timescale 1ns/1ps
`default_nettype none

module outputSelect import interpPkg::*; (
    input  wire             clk,
    input  wire             reset,
    input  wire             sampleEn,
    input  wire sample_t    dataIn,
    input  wire sample_t    scaled,
    interpCfgIf.datapath    cfg,
    output sample_t         dataOut
);

    sample_t bypassVal;
    sample_t pathVal;

    // Negation clamps the most negative value
    function automatic sample_t applyInvert(input sample_t value, input logic invert);
        sample_t result;
        if (invert) begin
            result = saturate(-wide_t'(value));
        end else begin
            result = value;
        end
        return result;
    endfunction

    assign bypassVal = applyInvert(dataIn, cfg.invert);
    assign pathVal = applyInvert(scaled, cfg.invert);

    // Test value wins, then bypass at the sample rate, then the filtered path
    always_ff @(posedge clk) begin
        if (reset) begin
            dataOut <= '0;
        end else if (cfg.test) begin
            dataOut <= cfg.testValue;
        end else if (cfg.bypass) begin
            if (sampleEn) begin
                dataOut <= bypassVal;
            end
        end else begin
            dataOut <= pathVal;
        end
    end

endmodule

`default_nettype wire

//--- tbInterpolate.sv
`timescale 1ns/1ps
`default_nettype none

module tbInterpolate import interpPkg::*; ();

    localparam int timeoutCycles = 2000;
    localparam int settleCycles = 48;
    localparam int restartCycles = 64;
    localparam sample_t minSample = sample_t'(18'h20000);
    localparam sample_t maxSample = sample_t'(18'h1FFFF);

    logic                   clk;
    logic                   reset;
    logic                   awvalid;
    logic                   awready;
    logic [addrWidth-1:0]   awaddr;
    logic                   wvalid;
    logic                   wready;
    logic [dataWidth-1:0]   wdata;
    logic [dataWidth/8-1:0] wstrb;
    logic                   bvalid;
    logic                   bready;
    logic [1:0]             bresp;
    logic                   arvalid;
    logic                   arready;
    logic [addrWidth-1:0]   araddr;
    logic                   rvalid;
    logic                   rready;
    logic [dataWidth-1:0]   rdata;
    logic [1:0]             rresp;
    sample_t                dataIn;
    logic                   sampleEn;
    sample_t                dataOut;

    logic [31:0] rngState;
    logic [31:0] stimRand;
    logic [1:0]  phase;
    int          checkCount;
    int          errorCount;
    int          startChecks;
    int          startErrors;
    logic        hung;
    logic        armed;
    logic        tracking;
    logic        invertOn;
    logic        randomSamples;
    sample_t     expVal;
    sample_t     dcLevel;
    longint      coefSet [firTaps];
    logic [31:0] regShadow [regCount];

    interpolate u_interpolate (
        .clk(clk), .reset(reset),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .dataIn(dataIn), .sampleEn(sampleEn), .dataOut(dataOut)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic longint clampSample(input longint v);
        if (v > 131071) begin
            return 131071;
        end else if (v < -131072) begin
            return -131072;
        end
        return v;
    endfunction

    function automatic sample_t refInvert(input sample_t v, input logic inv);
        return sample_t'(inv ? clampSample(-longint'(v)) : longint'(v));
    endfunction

    // Steady output for a constant input: FIR, CIC gain, shift, mantissa, invert
    function automatic sample_t expectDc(input sample_t x, input logic skipFir,
                                         input int expo, input sample_t mant, input logic inv);
        longint coefSum;
        longint firVal;
        longint cicVal;
        longint shifted;
        longint scaledVal;
        coefSum = 0;
        for (int k = 0; k < firTaps; k++) begin
            coefSum += coefSet[k];
        end
        firVal = skipFir ? longint'(x) : clampSample((longint'(x) * coefSum) >>> fracBits);
        cicVal = firVal * (interpRate ** (cicStages - 1));
        shifted = clampSample(cicVal >>> expo);
        scaledVal = clampSample((shifted * longint'(mant)) >>> fracBits);
        return refInvert(sample_t'(scaledVal), inv);
    endfunction

    function automatic logic [31:0] regMask(input int idx);
        case (idx)
            0: return 32'hF;
            2: return 32'h1F;
            default: return 32'h3FFFF;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic timeoutHit(input string what);
        $display("Timeout while waiting for %s", what);
        errorCount++;
        hung = 1'b1;
    endtask

    // Samples go out every 4th clock
    always @(posedge clk) begin
        if (reset) begin
            phase <= '0;
            sampleEn <= 1'b0;
        end else begin
            phase <= phase + 2'd1;
            sampleEn <= (phase == 2'd3);
            if (phase == 2'd3) begin
                stimRand = randomSamples ? nextRandom() : 32'd0;
                if (!randomSamples) begin
                    dataIn <= dcLevel;
                end else if (stimRand[3:0] == 4'd0) begin
                    dataIn <= minSample;
                end else begin
                    dataIn <= sample_t'(stimRand[17:0]);
                end
            end
        end
    end

    // Compare dataOut every clock while armed
    always @(posedge clk) begin
        if (tracking && sampleEn) begin
            expVal <= refInvert(dataIn, invertOn);
        end
        if (armed) begin
            checkValue("dataOut", dataOut, expVal);
        end
    end

    task automatic axiWrite(input logic [addrWidth-1:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
        int n;
        logic done;
        resp = 2'b11;
        if (hung) return;
        awaddr <= addr;
        wdata <= data;
        wstrb <= strb;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        done = 1'b0;
        for (n = 0; n < timeoutCycles && !done; n++) begin
            @(posedge clk);
            done = awready && wready;
        end
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        if (!done) begin
            timeoutHit("AXI write handshake");
            return;
        end
        done = 1'b0;
        for (n = 0; n < timeoutCycles && !done; n++) begin
            @(posedge clk);
            done = bvalid;
        end
        if (!done) begin
            timeoutHit("AXI write response");
            return;
        end
        resp = bresp;
    endtask

    task automatic axiRead(input logic [addrWidth-1:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
        int n;
        logic done;
        data = '0;
        resp = 2'b11;
        if (hung) return;
        araddr <= addr;
        arvalid <= 1'b1;
        done = 1'b0;
        for (n = 0; n < timeoutCycles && !done; n++) begin
            @(posedge clk);
            done = arready;
        end
        arvalid <= 1'b0;
        if (!done) begin
            timeoutHit("AXI read address handshake");
            return;
        end
        done = 1'b0;
        for (n = 0; n < timeoutCycles && !done; n++) begin
            @(posedge clk);
            done = rvalid;
        end
        if (!done) begin
            timeoutHit("AXI read data");
            return;
        end
        data = rdata;
        resp = rresp;
    endtask

    task automatic writeReg(input logic [addrWidth-1:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axiWrite(addr, data, 4'hF, resp);
        if (!hung) begin
            checkValue("bresp", resp, respOkay);
        end
    endtask

    task automatic waitSample();
        int n;
        logic done;
        if (hung) return;
        done = 1'b0;
        for (n = 0; n < timeoutCycles && !done; n++) begin
            @(posedge clk);
            done = sampleEn;
        end
        if (!done) timeoutHit("sampleEn");
    endtask

    task automatic waitSettled(input string what);
        sample_t prev;
        int stable;
        int n;
        if (hung) return;
        prev = dataOut;
        stable = 0;
        for (n = 0; n < timeoutCycles && stable < settleCycles; n++) begin
            @(posedge clk);
            stable = (dataOut === prev) ? stable + 1 : 0;
            prev = dataOut;
        end
        if (stable < settleCycles) timeoutHit(what);
    endtask

    // A cleared CIC drops the path output to zero for a few cycles
    task automatic waitZero(input string what);
        int n;
        logic seen;
        if (hung) return;
        seen = 1'b0;
        for (n = 0; n < restartCycles && !seen; n++) begin
            @(posedge clk);
            seen = (dataOut === '0);
        end
        checkCount++;
        if (!seen) begin
            errorCount++;
            $display("No %s seen on dataOut", what);
        end
    endtask

    task automatic checkDc(input sample_t expected);
        if (hung) return;
        expVal <= expected;
        armed <= 1'b1;
        repeat (8) @(posedge clk);
        armed <= 1'b0;
    endtask

    task automatic endTest(input string name);
        $display("%s: %0d checks, %0d errors", name, checkCount - startChecks,
                 errorCount - startErrors);
        startChecks = checkCount;
        startErrors = errorCount;
    endtask

    task automatic readBackAll();
        logic [31:0] rd;
        logic [1:0]  resp;
        for (int i = 0; i < regCount; i++) begin
            axiRead(addrWidth'(4 * i), rd, resp);
            checkValue("rdata", rd, regShadow[i]);
            checkValue("rresp", resp, respOkay);
        end
    endtask

    task automatic testRegisters();
        logic [31:0] data;
        logic [31:0] word;
        logic [3:0]  strb;
        logic [1:0]  resp;
        for (int i = 0; i < regCount; i++) begin
            regShadow[i] = (i == 3 || i == 4) ? 32'h10000 : 32'h0;
        end
        readBackAll();
        for (int round = 0; round < 3; round++) begin
            for (int i = 0; i < regCount; i++) begin
                data = nextRandom();
                strb = nextRandom() & 32'hF;
                axiWrite(addrWidth'(4 * i), data, strb, resp);
                checkValue("bresp", resp, respOkay);
                word = regShadow[i];
                for (int b = 0; b < 4; b++) begin
                    if (strb[b]) word[8*b +: 8] = data[8*b +: 8];
                end
                regShadow[i] = word & regMask(i);
            end
            readBackAll();
        end
        axiWrite(6'h24, nextRandom(), 4'hF, resp);
        checkValue("bresp", resp, respSlvErr);
        axiRead(6'h3C, data, resp);
        checkValue("rresp", resp, respSlvErr);
        checkValue("rdata", data, 32'h0);
        readBackAll();
    endtask

    task automatic testTestValue();
        sample_t v;
        writeReg(regControl, 32'h2);
        for (int i = 0; i < 8 && !hung; i++) begin
            v = sample_t'(nextRandom() & 32'h3FFFF);
            writeReg(regTestValue, {14'b0, v});
            expVal <= v;
            armed <= 1'b1;
            @(posedge clk);
            armed <= 1'b0;
        end
        writeReg(regControl, 32'h0);
    endtask

    task automatic testBypass();
        logic inv;
        randomSamples <= 1'b1;
        for (int pass = 0; pass < 2 && !hung; pass++) begin
            inv = pass[0];
            invertOn <= inv;
            writeReg(regControl, {29'b0, inv, 2'b01});
            tracking <= 1'b1;
            waitSample();
            waitSample();
            armed <= 1'b1;
            repeat (12) waitSample();
            armed <= 1'b0;
            tracking <= 1'b0;
        end
        randomSamples <= 1'b0;
    endtask

    task automatic testDcGain();
        logic [31:0] r;
        sample_t     dc;
        sample_t     coef;
        sample_t     mant;
        int          expo;
        logic        inv;
        for (int i = 0; i < 5 && !hung; i++) begin
            r = nextRandom();
            dc = (i < 4) ? sample_t'(r[17:0]) : maxSample;
            expo = (i < 4) ? 2 + int'(r[19:18]) : 0;
            inv = (i < 4) ? r[20] : 1'b1;
            mant = (i < 4) ? sample_t'(nextRandom() & 32'h3FFFF) : maxSample;
            dcLevel <= dc;
            for (int k = 0; k < firTaps; k++) begin
                r = nextRandom();
                coef = {r[16], r[16:0]};
                // Last setting drives every stage into saturation
                if (i == 4) coef = (k == 0) ? maxSample : '0;
                coefSet[k] = coef;
                writeReg(regCoef0 + addrWidth'(4 * k), {14'b0, coef});
            end
            writeReg(regExponent, expo);
            writeReg(regMantissa, {14'b0, mant});
            writeReg(regControl, {29'b0, inv, 2'b00});
            waitSettled("DC output to settle");
            checkDc(expectDc(dc, 1'b0, expo, mant, inv));
        end
    endtask

    task automatic testEqBypassRestart();
        sample_t dc;
        sample_t mant;
        dc = sample_t'((nextRandom() & 32'h1FFFF) | 32'h1000);
        mant = sample_t'(32'h8000 + (nextRandom() & 32'hFFFF));
        dcLevel <= dc;
        writeReg(regExponent, 32'd3);
        writeReg(regMantissa, {14'b0, mant});
        writeReg(regControl, 32'h8);
        waitSettled("equalizer bypass output to settle");
        checkDc(expectDc(dc, 1'b1, 3, mant, 1'b0));
        // Park in full bypass with the input held, then leave bypass
        writeReg(regControl, 32'h1);
        repeat (8) waitSample();
        writeReg(regControl, 32'h0);
        waitZero("CIC restart after bypass exit");
        waitSettled("output to settle after restart");
        dcLevel <= '0;
        waitSettled("output to return to zero");
        checkDc('0);
    endtask

    initial begin
        rngState = 32'd94578;
        checkCount = 0;
        errorCount = 0;
        startChecks = 0;
        startErrors = 0;
        hung = 1'b0;
        armed = 1'b0;
        tracking = 1'b0;
        invertOn = 1'b0;
        randomSamples = 1'b0;
        expVal = '0;
        dcLevel = '0;
        clk = 1'b0;
        reset = 1'b1;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        bready = 1'b1;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b1;
        dataIn = '0;
        sampleEn = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        checkValue("dataOut", dataOut, 32'h0);
        testRegisters();
        endTest("register access");
        if (!hung) begin
            testTestValue();
            endTest("test value");
        end
        if (!hung) begin
            testBypass();
            endTest("full bypass with invert");
        end
        if (!hung) begin
            testDcGain();
            endTest("DC gain through full path");
        end
        if (!hung) begin
            testEqBypassRestart();
            endTest("equalizer bypass and restart");
        end
        $display("Total: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
